//--- list.f
+incdir+verif
hw/aes_pkg.sv
hw/aes_ctrl.sv
hw/aes_round.sv
hw/aes_result.sv
hw/aes_encrypt_top.sv
verif/aes_tb.sv

//--- run.sh
#!/bin/sh
# Builds the AES testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module aes_tb -f list.f \
  --Mdir obj_dir -o aes_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/aes_tb_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: the pass line was not found"
  exit 1
fi

//--- verif/aes_ref.svh
// ######################################
// Reference model for the AES testbench.
// Included inside the testbench module.
// ######################################
`ifndef AES_REF_SVH
`define AES_REF_SVH

// SubWord passes each byte of a key word through the S-box.
function automatic logic [31:0] sub_word(input logic [31:0] w);
  return {aes_pkg::SBOX[w[31:24]], aes_pkg::SBOX[w[23:16]],
          aes_pkg::SBOX[w[15:8]], aes_pkg::SBOX[w[7:0]]};
endfunction

// Key expansion from the standard.
// The cipher key is left-aligned in 256 bits with its first byte on top.
// Round key r is made of the words 4r to 4r+3, and entries past Nr stay zero.
function automatic aes_pkg::key_words_t expand_key(input logic [255:0]       key,
                                                   input aes_pkg::key_size_e ks);
  logic [31:0]         w [0:59];
  logic [31:0]         t;
  logic [7:0]          rcon;
  int                  nr;
  int                  nk;
  aes_pkg::key_words_t kw;
  nr   = int'(aes_pkg::num_rounds(ks));
  nk   = nr - 6;
  rcon = 8'h01;
  kw   = '0;
  for (int i = 0; i < nk; i++) begin
    w[i] = key[255 - 32 * i -: 32];
  end
  for (int i = nk; i < 4 * (nr + 1); i++) begin
    t = w[i - 1];
    if (i % nk == 0) begin
      // RotWord, SubWord and the round constant.
      t    = sub_word({t[23:0], t[31:24]}) ^ {rcon, 24'h000000};
      rcon = aes_pkg::xtime(rcon);
    end else if (nk == 8 && i % nk == 4) begin
      // A 256-bit key has an extra SubWord in the middle of each group.
      t = sub_word(t);
    end
    w[i] = w[i - nk] ^ t;
  end
  for (int r = 0; r <= nr; r++) begin
    kw[r] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
  end
  return kw;
endfunction

// Whole-block encrypt, written as the cipher loop of the standard.
function automatic aes_pkg::state_t encrypt_block(input aes_pkg::state_t     pt,
                                                  input aes_pkg::key_words_t kw,
                                                  input aes_pkg::key_size_e  ks);
  aes_pkg::state_t s;
  int              nr;
  nr = int'(aes_pkg::num_rounds(ks));
  s  = pt ^ kw[0];
  for (int r = 1; r <= nr; r++) begin
    s = aes_pkg::shift_rows(aes_pkg::sub_bytes(s));
    // The last round has no MixColumns.
    if (r != nr) begin
      s = aes_pkg::mix_columns(s);
    end
    s = s ^ kw[r];
  end
  return s;
endfunction

`endif

//--- verif/aes_tb.sv
// ######################################
// Self-checking testbench of the AES encryptor top level.
// Build and run it with run.sh.
// ######################################
`timescale 1ns/1ps

module aes_tb;

  `include "aes_ref.svh"

  localparam int CLK_PERIOD     = 100;
  localparam int NUM_RANDOM     = 30;
  localparam int NUM_TESTS      = NUM_RANDOM + 5;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 20 + 100;

  // Known-answer vectors of the standard.
  // The keys are left-aligned in 256 bits.
  localparam aes_pkg::state_t KAT_PT      = 128'h00112233445566778899aabbccddeeff;
  localparam logic [255:0]    KAT_KEY_128 = {128'h000102030405060708090a0b0c0d0e0f, 128'h0};
  localparam logic [255:0]    KAT_KEY_192 =
    {192'h000102030405060708090a0b0c0d0e0f1011121314151617, 64'h0};
  localparam logic [255:0]    KAT_KEY_256 =
    256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;

  logic                eph1;
  logic                arst_n;
  logic                start;
  aes_pkg::state_t     plaintext;
  aes_pkg::key_size_e  key_size;
  aes_pkg::key_words_t key_words;
  logic                busy;
  logic                done;
  logic                finished;
  aes_pkg::state_t     ciphertext;

  // Expected ciphertext of the request that is on the inputs right now.
  aes_pkg::state_t     drv_exp;

  // Model of the handshake. age is 1 in the cycle after acceptance and
  // reaches done_age in the cycle where done_o must be high.
  logic [4:0]          age;
  logic [4:0]          done_age;
  aes_pkg::state_t     exp_ct;
  aes_pkg::state_t     last_ct;
  logic                seen_done;
  logic                model_done;
  logic                model_busy;
  logic                past_first;
  int                  errors;
  int                  completed;

  always #(CLK_PERIOD / 2) eph1 = ~eph1;

  aes_encrypt_top dut_i (
    .eph1_i       (eph1),
    .arst_n_i     (arst_n),
    .start_i      (start),
    .plaintext_i  (plaintext),
    .key_size_i   (key_size),
    .key_words_i  (key_words),
    .busy_o       (busy),
    .done_o       (done),
    .finished_o   (finished),
    .ciphertext_o (ciphertext)
  );

  assign model_done = (age != 5'd0) && (age == done_age);
  assign model_busy = (age != 5'd0) && !model_done;

  // A request is taken when start is high and the model is idle.
  // The expected block and the due cycle are latched at that edge.
  always_ff @(posedge eph1 or negedge arst_n) begin
    if (!arst_n) begin
      age       <= 5'd0;
      done_age  <= 5'd0;
      exp_ct    <= '0;
      last_ct   <= '0;
      seen_done <= 1'b0;
    end else begin
      last_ct   <= ciphertext;
      seen_done <= seen_done | model_done;
      if (start && !model_busy) begin
        age      <= 5'd1;
        done_age <= {1'b0, aes_pkg::num_rounds(key_size)} + 5'd3;
        exp_ct   <= drv_exp;
      end else if (model_done) begin
        age <= 5'd0;
      end else if (age != 5'd0) begin
        age <= age + 5'd1;
      end
    end
  end

  task automatic flag_mismatch(input string msg);
    errors = errors + 1;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  reset_values_a : assert property (@(posedge eph1)
    (!arst_n && past_first) |-> (!busy && !done && !finished && ciphertext == '0))
    else flag_mismatch("outputs are not cleared during reset");

  busy_window_a : assert property (@(posedge eph1) disable iff (!arst_n)
    busy == model_busy)
    else flag_mismatch("busy_o does not cover exactly the accepted block");

  done_timing_a : assert property (@(posedge eph1) disable iff (!arst_n)
    done == model_done)
    else flag_mismatch("done_o is not a single pulse Nr+2 edges after start");

  ciphertext_a : assert property (@(posedge eph1) disable iff (!arst_n)
    model_done |-> (ciphertext == exp_ct))
    else flag_mismatch("ciphertext_o differs from the expected block at done_o");

  hold_a : assert property (@(posedge eph1) disable iff (!arst_n)
    !model_done |-> (ciphertext == last_ct))
    else flag_mismatch("ciphertext_o changed between done_o pulses");

  sticky_a : assert property (@(posedge eph1) disable iff (!arst_n)
    finished == (seen_done || model_done))
    else flag_mismatch("finished_o does not follow the first completion");

  function automatic aes_pkg::state_t random_block();
    aes_pkg::state_t b;
    for (int i = 0; i < 4; i++) begin
      b[4 * i +: 4] = $urandom;
    end
    return b;
  endfunction

  function automatic logic [255:0] random_key();
    logic [255:0] k;
    for (int i = 0; i < 8; i++) begin
      k[32 * i +: 32] = $urandom;
    end
    return k;
  endfunction

  // Scrambles every data input with start_i low, one cycle at a time.
  task automatic drive_random_inputs(input int cycles);
    logic [31:0] rnd;
    repeat (cycles) begin
      @(negedge eph1);
      rnd       = $urandom;
      start     = 1'b0;
      plaintext = random_block();
      key_size  = aes_pkg::key_size_e'(rnd[1:0]);
      for (int r = 0; r <= aes_pkg::AES_MAX_ROUNDS; r++) begin
        key_words[r] = random_block();
      end
    end
  endtask

  // One-cycle start pulse with the request on the inputs.
  task automatic send_request(input aes_pkg::state_t     pt,
                              input aes_pkg::key_size_e  ks,
                              input aes_pkg::key_words_t kw,
                              input aes_pkg::state_t     expected);
    @(negedge eph1);
    start     = 1'b1;
    plaintext = pt;
    key_size  = ks;
    key_words = kw;
    drv_exp   = expected;
    @(negedge eph1);
    start = 1'b0;
  endtask

  // Inputs keep changing while the block is in flight.
  task automatic wait_done();
    while (!done) begin
      drive_random_inputs(1);
    end
    completed = completed + 1;
  endtask

  task automatic run_known_answer(input logic [255:0]       key,
                                  input aes_pkg::key_size_e ks,
                                  input aes_pkg::state_t    expected);
    aes_pkg::key_words_t kw;
    kw = expand_key(key, ks);
    send_request(KAT_PT, ks, kw, expected);
    wait_done();
    drive_random_inputs(2);
  endtask

  // Random block, key and key size.
  // The key size code 11 is drawn as well.
  task automatic run_random_request();
    aes_pkg::state_t     pt;
    aes_pkg::key_size_e  ks;
    aes_pkg::key_words_t kw;
    logic [31:0]         rnd;
    pt  = random_block();
    rnd = $urandom;
    ks  = aes_pkg::key_size_e'(rnd[1:0]);
    kw  = expand_key(random_key(), ks);
    send_request(pt, ks, kw, encrypt_block(pt, kw, ks));
    wait_done();
    drive_random_inputs(2);
  endtask

  initial begin : stimulus
    aes_pkg::state_t     pt;
    aes_pkg::key_words_t kw;
    void'($urandom(2));
    errors     = 0;
    completed  = 0;
    past_first = 1'b0;
    eph1       = 1'b0;
    arst_n     = 1'b0;
    start      = 1'b0;
    plaintext  = '0;
    key_size   = aes_pkg::KEY_128;
    key_words  = '0;
    drv_exp    = '0;
    // Reset values are checked from the second edge of the reset on.
    @(posedge eph1);
    past_first = 1'b1;
    repeat (3) @(posedge eph1);
    @(negedge eph1);
    arst_n = 1'b1;

    run_known_answer(KAT_KEY_128, aes_pkg::KEY_128, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    run_known_answer(KAT_KEY_192, aes_pkg::KEY_192, 128'hdda97ca4864cdfe06eaf70a0ec0d7191);
    run_known_answer(KAT_KEY_256, aes_pkg::KEY_256, 128'h8ea2b7ca516745bfeafc49904b496089);

    repeat (NUM_RANDOM) begin
      run_random_request();
    end

    // A second pulse in the middle of a block must be dropped.
    pt = random_block();
    kw = expand_key(random_key(), aes_pkg::KEY_128);
    send_request(pt, aes_pkg::KEY_128, kw, encrypt_block(pt, kw, aes_pkg::KEY_128));
    drive_random_inputs(3);
    pt = random_block();
    kw = expand_key(random_key(), aes_pkg::KEY_256);
    send_request(pt, aes_pkg::KEY_256, kw, encrypt_block(pt, kw, aes_pkg::KEY_256));
    wait_done();
    drive_random_inputs(20);

    $display("Summary: %0d check failures, %0d requests completed", errors, completed);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- hw/aes_encrypt_top.sv
// ######################################
// Top level of the iterative AES encryptor.
// Pulse start_i while idle, then wait for done_o.
// ######################################
`timescale 1ns/1ps

module aes_encrypt_top (
  input  logic                  eph1_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  aes_pkg::state_t       plaintext_i,
  input  aes_pkg::key_size_e    key_size_i,
  input  aes_pkg::key_words_t   key_words_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  finished_o,
  output aes_pkg::state_t       ciphertext_o
);

  // Captured plaintext from the sequencer to the datapath.
  aes_pkg::state_t     plaintext;

  // Round control for the current cycle.
  aes_pkg::round_ctl_t round_ctl;

  // Datapath state and its completion marker.
  aes_pkg::state_t     state;
  logic                last_done;

  // Sequencer. Accepts the request and steps through the rounds.
  aes_ctrl u_ctrl (
    .eph1_i      (eph1_i),
    .arst_n_i    (arst_n_i),
    .start_i     (start_i),
    .plaintext_i (plaintext_i),
    .key_size_i  (key_size_i),
    .key_words_i (key_words_i),
    .busy_o      (busy_o),
    .plaintext_o (plaintext),
    .round_ctl_o (round_ctl)
  );

  // Round datapath, one round per clock.
  aes_round u_round (
    .eph1_i      (eph1_i),
    .arst_n_i    (arst_n_i),
    .round_ctl_i (round_ctl),
    .plaintext_i (plaintext),
    .state_o     (state),
    .last_done_o (last_done)
  );

  // Output stage that holds the ciphertext.
  aes_result u_result (
    .eph1_i       (eph1_i),
    .arst_n_i     (arst_n_i),
    .state_i      (state),
    .last_done_i  (last_done),
    .done_o       (done_o),
    .finished_o   (finished_o),
    .ciphertext_o (ciphertext_o)
  );

endmodule

//--- hw/aes_result.sv
// ######################################
// Ciphertext capture with done pulse and sticky finished flag.
// ######################################
`timescale 1ns/1ps

module aes_result (
  input  logic              eph1_i,
  input  logic              arst_n_i,
  input  aes_pkg::state_t   state_i,
  input  logic              last_done_i,
  output logic              done_o,
  output logic              finished_o,
  output aes_pkg::state_t   ciphertext_o
);

  logic            done_q;
  logic            finished_q;
  aes_pkg::state_t cipher_q;

  // The ciphertext holds until the next block completes.
  // finished stays set until reset once any block is done.
  always_ff @(posedge eph1_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q     <= 1'b0;
      finished_q <= 1'b0;
      cipher_q   <= '0;
    end else begin
      done_q     <= last_done_i;
      finished_q <= finished_q | last_done_i;
      if (last_done_i) begin
        cipher_q <= state_i;
      end
    end
  end

  assign done_o       = done_q;
  assign finished_o   = finished_q;
  assign ciphertext_o = cipher_q;

  // One block gives exactly one done pulse.
  done_single_a : assert property (@(posedge eph1_i) disable iff (!arst_n_i)
    done_q |=> !done_q);

endmodule

//--- hw/aes_round.sv
// ######################################
// Cipher state register with one AES round per clock.
// Loads the whitened block, then applies Nr rounds.
// ######################################
`timescale 1ns/1ps

module aes_round (
  input  logic                  eph1_i,
  input  logic                  arst_n_i,
  input  aes_pkg::round_ctl_t   round_ctl_i,
  input  aes_pkg::state_t       plaintext_i,
  output aes_pkg::state_t       state_o,
  output logic                  last_done_o
);

  // Working block between rounds.
  aes_pkg::state_t state_q;

  // Intermediate values of the current round.
  aes_pkg::state_t sub_out;
  aes_pkg::state_t shift_out;
  aes_pkg::state_t mix_out;
  aes_pkg::state_t pre_key;
  aes_pkg::state_t round_out;
  aes_pkg::state_t whiten;

  logic last_done_q;

  // SubBytes comes first, then ShiftRows moves the bytes between columns.
  assign sub_out   = aes_pkg::sub_bytes(state_q);
  assign shift_out = aes_pkg::shift_rows(sub_out);

  // MixColumns works on the shifted columns.
  assign mix_out = aes_pkg::mix_columns(shift_out);

  // The final round has no MixColumns, so the shifted block goes straight to the key.
  assign pre_key = round_ctl_i.last ? shift_out : mix_out;

  // AddRoundKey closes every round.
  assign round_out = pre_key ^ round_ctl_i.round_key;

  // Initial whitening uses round key 0, which control presents in the load cycle.
  assign whiten = plaintext_i ^ round_ctl_i.round_key;

  // A load cycle whitens a new block, and a round cycle advances the current one.
  always_ff @(posedge eph1_i) begin
    if (round_ctl_i.load) begin
      state_q <= whiten;
    end else if (round_ctl_i.active) begin
      state_q <= round_out;
    end
  end

  // Marks that the state now holds the ciphertext.
  // It is high for one cycle after the final round's edge.
  always_ff @(posedge eph1_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_done_q <= 1'b0;
    end else begin
      last_done_q <= round_ctl_i.active & round_ctl_i.last;
    end
  end

  assign state_o     = state_q;
  assign last_done_o = last_done_q;

  // The sequencer must never ask for a reload in the middle of a round.
  load_active_excl_a : assert property (@(posedge eph1_i) disable iff (!arst_n_i)
    !(round_ctl_i.load && round_ctl_i.active));

endmodule

//--- hw/aes_ctrl.sv
// ######################################
// Request capture and round sequencer of the AES encryptor.
// Drives load, active, last and the round key to the datapath.
// ######################################
`timescale 1ns/1ps

module aes_ctrl (
  input  logic                   eph1_i,
  input  logic                   arst_n_i,
  input  logic                   start_i,
  input  aes_pkg::state_t        plaintext_i,
  input  aes_pkg::key_size_e     key_size_i,
  input  aes_pkg::key_words_t    key_words_i,
  output logic                   busy_o,
  output aes_pkg::state_t        plaintext_o,
  output aes_pkg::round_ctl_t    round_ctl_o
);

  // A request is taken only while no block is in flight.
  logic                  accept;
  logic                  busy_q;
  logic                  drain_q;
  aes_pkg::round_idx_t   rnd_q;
  aes_pkg::round_idx_t   nr_q;
  aes_pkg::state_t       plaintext_q;
  aes_pkg::key_words_t   keys_q;
  logic                  run;

  assign accept = start_i & ~busy_q;

  // The request payload is sampled at the accepting edge and held for the whole block.
  always_ff @(posedge eph1_i) begin
    if (accept) begin
      plaintext_q <= plaintext_i;
      keys_q      <= key_words_i;
    end
  end

  // Sequence per block.
  // Count 0 is the whitening load, counts 1..Nr are rounds.
  // The drain cycle lets the result stage capture before busy drops.
  always_ff @(posedge eph1_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      drain_q <= 1'b0;
      rnd_q   <= '0;
      nr_q    <= '0;
    end else if (accept) begin
      busy_q  <= 1'b1;
      drain_q <= 1'b0;
      rnd_q   <= '0;
      nr_q    <= aes_pkg::num_rounds(key_size_i);
    end else if (busy_q) begin
      if (drain_q) begin
        busy_q  <= 1'b0;
        drain_q <= 1'b0;
      end else if (round_ctl_o.last) begin
        drain_q <= 1'b1;
      end else begin
        rnd_q <= rnd_q + 4'd1;
      end
    end
  end

  // Cycles that touch the state register.
  assign run = busy_q & ~drain_q;

  always_comb begin
    round_ctl_o.load      = run & (rnd_q == '0);
    round_ctl_o.active    = run & (rnd_q != '0);
    round_ctl_o.last      = run & (rnd_q != '0) & (rnd_q == nr_q);
    round_ctl_o.round_key = keys_q[rnd_q];
  end

  assign busy_o      = busy_q;
  assign plaintext_o = plaintext_q;

  // The key index stays inside the range the decoded key size allows.
  rnd_in_range_a : assert property (@(posedge eph1_i) disable iff (!arst_n_i)
    busy_q |-> (rnd_q <= nr_q));

endmodule

//--- hw/aes_pkg.sv
// ######################################
// Shared AES types, the forward S-box and the round transforms.
// RTL and testbench reach these by scoped names.
// ######################################
package aes_pkg;

  // A block holds 16 bytes, and a 256-bit key needs 14 rounds.
  localparam int AES_NB_BYTES   = 16;
  localparam int AES_MAX_ROUNDS = 14;

  // Column-major block.
  // Byte 15 sits in bits 127:120 and is the first byte of the standard.
  // Column c holds bytes 15-4c down to 12-4c, with row 0 on top.
  typedef logic [AES_NB_BYTES-1:0][7:0] state_t;

  // Pre-expanded round keys, with round key 0 at index 0.
  typedef state_t [AES_MAX_ROUNDS:0] key_words_t;

  // Key size code.
  // The unused code 2'b11 is treated as a 256-bit key.
  typedef enum logic [1:0] {
    KEY_128 = 2'b00,
    KEY_192 = 2'b01,
    KEY_256 = 2'b10
  } key_size_e;

  typedef logic [3:0] round_idx_t;

  // Per-cycle control from the sequencer to the round datapath.
  typedef struct packed {
    logic   load;
    logic   active;
    logic   last;
    state_t round_key;
  } round_ctl_t;

  // Forward S-box in natural order, so SBOX[8'h00] is 8'h63.
  localparam logic [0:255][7:0] SBOX = {
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5, 8'h30, 8'h01, 8'h67, 8'h2b,
    8'hfe, 8'hd7, 8'hab, 8'h76, 8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0, 8'hb7, 8'hfd, 8'h93, 8'h26,
    8'h36, 8'h3f, 8'hf7, 8'hcc, 8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a, 8'h07, 8'h12, 8'h80, 8'he2,
    8'heb, 8'h27, 8'hb2, 8'h75, 8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84, 8'h53, 8'hd1, 8'h00, 8'hed,
    8'h20, 8'hfc, 8'hb1, 8'h5b, 8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85, 8'h45, 8'hf9, 8'h02, 8'h7f,
    8'h50, 8'h3c, 8'h9f, 8'ha8, 8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2, 8'hcd, 8'h0c, 8'h13, 8'hec,
    8'h5f, 8'h97, 8'h44, 8'h17, 8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88, 8'h46, 8'hee, 8'hb8, 8'h14,
    8'hde, 8'h5e, 8'h0b, 8'hdb, 8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79, 8'he7, 8'hc8, 8'h37, 8'h6d,
    8'h8d, 8'hd5, 8'h4e, 8'ha9, 8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6, 8'he8, 8'hdd, 8'h74, 8'h1f,
    8'h4b, 8'hbd, 8'h8b, 8'h8a, 8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e, 8'he1, 8'hf8, 8'h98, 8'h11,
    8'h69, 8'hd9, 8'h8e, 8'h94, 8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68, 8'h41, 8'h99, 8'h2d, 8'h0f,
    8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Round count from the key size. Bit 1 alone selects 256, as 2'b11 does too.
  function automatic round_idx_t num_rounds(input key_size_e ks);
    if (ks[1]) return 4'd14;
    else if (ks[0]) return 4'd12;
    else return 4'd10;
  endfunction

  // Multiply by x in GF(2^8), reducing by the AES polynomial 0x11b.
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // SubBytes looks every byte up in the S-box.
  function automatic state_t sub_bytes(input state_t s);
    state_t o;
    for (int i = 0; i < AES_NB_BYTES; i++) begin
      o[i] = SBOX[s[i]];
    end
    return o;
  endfunction

  // ShiftRows rotates row r left by r columns.
  // Row r of column c is byte 15-(4c+r).
  function automatic state_t shift_rows(input state_t s);
    state_t o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[15 - (4 * c + r)] = s[15 - (4 * ((c + r) % 4) + r)];
      end
    end
    return o;
  endfunction

  // MixColumns multiplies each column by the circulant matrix {2,3,1,1}.
  // A multiply by 3 is xtime(a) ^ a.
  function automatic state_t mix_columns(input state_t s);
    state_t     o;
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      a0 = s[15 - 4 * c];
      a1 = s[14 - 4 * c];
      a2 = s[13 - 4 * c];
      a3 = s[12 - 4 * c];
      o[15 - 4 * c] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      o[14 - 4 * c] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      o[13 - 4 * c] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      o[12 - 4 * c] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
    return o;
  endfunction

endpackage
